// ==== Makefile ====
# Verilator build and run for the SRAM controller testbench

TOP = sram_controller_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f list.f -o $(TOP)

# the binary exits non-zero when the testbench stops with $fatal
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== list.f ====
sram_pkg.sv
mem_request_stage.sv
sram_sequencer.sv
sram_controller.sv
sram_chip_model.sv
sram_controller_tb.sv

// ==== mem_request_stage.sv ====
`default_nettype none

module mem_request_stage #(
    parameter int sram_addr_bits = 18
) (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire                                  mem_valid,
    input  wire  [sram_pkg::addr_width-1:0]      mem_addr,
    input  wire  [sram_pkg::data_width-1:0]      mem_wdata,
    input  wire  [sram_pkg::strb_width-1:0]      mem_wstrb,
    input  wire                                  seq_done,
    output logic                                 req_start,
    output sram_pkg::mem_op_t                    req_op,
    output logic [sram_addr_bits-$clog2(sram_pkg::beats)-1:0] req_word,
    output logic [sram_pkg::data_width-1:0]      req_wdata,
    output logic [sram_pkg::strb_width-1:0]      req_wstrb,
    output logic                                 mem_ready,
    output logic                                 mem_error
);

    localparam int byte_bits = $clog2(sram_pkg::strb_width);  // offset inside a 64-bit word
    localparam int word_bits = sram_addr_bits - $clog2(sram_pkg::beats);

    logic busy_q;
    logic refuse_q;
    logic outstanding;
    logic accept;
    logic out_of_range;

    // a refused request is outstanding until its error pulse
    assign outstanding = busy_q | refuse_q;
    assign accept      = mem_valid & ~outstanding;

    // sram holds 2^sram_addr_bits halfwords, so byte address bits above that are illegal
    assign out_of_range = |mem_addr[sram_pkg::addr_width-1:sram_addr_bits+1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy_q    <= 1'b0;
            refuse_q  <= 1'b0;
            req_start <= 1'b0;
        end else begin
            req_start <= accept & ~out_of_range;
            refuse_q  <= accept & out_of_range;
            if (accept && !out_of_range) begin
                busy_q <= 1'b1;
            end else if (seq_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // request contents, held until the next accepted request
    always_ff @(posedge clock) begin
        if (accept) begin
            req_op    <= (|mem_wstrb) ? sram_pkg::op_write : sram_pkg::op_read;
            req_word  <= mem_addr[word_bits+byte_bits-1:byte_bits];
            req_wdata <= mem_wdata;
            req_wstrb <= mem_wstrb;
        end
    end

    assign mem_ready = seq_done | refuse_q;
    assign mem_error = refuse_q;    // never set on a completed access

    // the bus carries one request at a time
    assert property (@(posedge clock) disable iff (!reset)
        mem_valid |-> !outstanding)
        else $error("mem_valid raised while a request is outstanding");

    // the sequencer cannot finish in the cycle a new access starts
    assert property (@(posedge clock) disable iff (!reset)
        !(mem_ready && req_start))
        else $error("mem_ready and req_start in the same cycle");

endmodule

`default_nettype wire

// ==== sram_chip_model.sv ====
`default_nettype none

// behavioral asynchronous sram, 2^addr_bits halfwords with byte enables
module sram_chip_model #(
    parameter int addr_bits = 18
) (
    input  wire                 ce_n,
    input  wire                 we_n,
    input  wire                 oe_n,
    input  wire                 ub_n,
    input  wire                 lb_n,
    input  wire [addr_bits-1:0] addr,
    inout  wire [15:0]          dq
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [0:(2**addr_bits)-1];
    logic        reading;
    logic [15:0] read_word;

    // the unused byte lane is driven as well on a read
    assign reading   = !ce_n && !oe_n && we_n && !(ub_n && lb_n);
    assign read_word = mem[addr];
    assign dq        = reading ? read_word : {16{1'bz}};

    initial begin
        for (int i = 0; i < 2**addr_bits; i++) begin
            mem[i] = 16'h0000;   // fill value
        end
        forever begin
            @(ce_n or we_n or ub_n or lb_n or addr or dq);
            // let every pin of this edge settle before the array is written
            #0.1;
            if (!ce_n && !we_n) begin
                if (!lb_n) begin
                    mem[addr][7:0] = dq[7:0];
                end
                if (!ub_n) begin
                    mem[addr][15:8] = dq[15:8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sram_controller.sv ====
`default_nettype none

module sram_controller #(
    parameter int beat_cycles    = 3,   // at least 1
    parameter int sram_addr_bits = 18   // halfword address of the part
) (
    input  wire                             clock,
    input  wire                             reset,
    // memory bus
    input  wire                             mem_valid,
    input  wire  [sram_pkg::addr_width-1:0] mem_addr,
    input  wire  [sram_pkg::data_width-1:0] mem_wdata,
    input  wire  [sram_pkg::strb_width-1:0] mem_wstrb,
    output logic [sram_pkg::data_width-1:0] mem_rdata,
    output logic                            mem_ready,
    output logic                            mem_error,
    // sram pins
    output logic                            sram_ce_n,
    output logic                            sram_we_n,
    output logic                            sram_oe_n,
    output logic                            sram_ub_n,
    output logic                            sram_lb_n,
    output logic [sram_addr_bits-1:0]       sram_addr,
    inout  wire  [sram_pkg::dq_width-1:0]   sram_dq
);

    localparam int word_bits = sram_addr_bits - $clog2(sram_pkg::beats);

    logic                            req_start;
    sram_pkg::mem_op_t               req_op;
    logic [word_bits-1:0]            req_word;    // 64-bit word index
    logic [sram_pkg::data_width-1:0] req_wdata;
    logic [sram_pkg::strb_width-1:0] req_wstrb;
    logic                            seq_done;

    mem_request_stage #(
        .sram_addr_bits (sram_addr_bits)
    ) mem_request_stage_inst (
        .clock     (clock),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .seq_done  (seq_done),
        .req_start (req_start),
        .req_op    (req_op),
        .req_word  (req_word),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .mem_ready (mem_ready),
        .mem_error (mem_error)
    );

    sram_sequencer #(
        .beat_cycles    (beat_cycles),
        .sram_addr_bits (sram_addr_bits)
    ) sram_sequencer_inst (
        .clock     (clock),
        .reset     (reset),
        .req_start (req_start),
        .req_op    (req_op),
        .req_word  (req_word),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .seq_done  (seq_done),
        .seq_rdata (mem_rdata),     // read data goes straight to the bus
        .sram_ce_n (sram_ce_n),
        .sram_we_n (sram_we_n),
        .sram_oe_n (sram_oe_n),
        .sram_ub_n (sram_ub_n),
        .sram_lb_n (sram_lb_n),
        .sram_addr (sram_addr),
        .sram_dq   (sram_dq)
    );

endmodule

`default_nettype wire

// ==== sram_controller_tb.sv ====
`default_nettype none

module sram_controller_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int beat_cycles    = 3;
    localparam int sram_addr_bits = 18;
    localparam int reset_cycles   = 16;
    localparam int total_ops      = 300;
    localparam int directed_ops   = 4;
    localparam int timeout_cycles = total_ops * (4 * beat_cycles + 8) + reset_cycles;
    localparam logic [15:0] base_word = 16'h2a40;   // first word of the 16-word window

    logic                            clock;
    logic                            reset;
    logic                            mem_valid;
    logic [sram_pkg::addr_width-1:0] mem_addr;
    logic [sram_pkg::data_width-1:0] mem_wdata;
    logic [sram_pkg::strb_width-1:0] mem_wstrb;
    logic [sram_pkg::data_width-1:0] mem_rdata;
    logic                            mem_ready;
    logic                            mem_error;
    logic                            sram_ce_n;
    logic                            sram_we_n;
    logic                            sram_oe_n;
    logic                            sram_ub_n;
    logic                            sram_lb_n;
    logic [sram_addr_bits-1:0]       sram_addr;
    wire  [sram_pkg::dq_width-1:0]   sram_dq;

    logic [63:0] shadow [0:15];     // expected contents of the window
    logic [31:0] rng_state;
    logic        outstanding;
    logic        monitor_on;
    int          cycle_count;
    logic [sram_addr_bits-3:0] expected_word;   // word index of the request in flight
    int          select_cycles;                 // cycles since sram_ce_n fell

    sram_controller #(
        .beat_cycles    (beat_cycles),
        .sram_addr_bits (sram_addr_bits)
    ) sram_controller_inst (
        .clock     (clock),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .mem_error (mem_error),
        .sram_ce_n (sram_ce_n),
        .sram_we_n (sram_we_n),
        .sram_oe_n (sram_oe_n),
        .sram_ub_n (sram_ub_n),
        .sram_lb_n (sram_lb_n),
        .sram_addr (sram_addr),
        .sram_dq   (sram_dq)
    );

    sram_chip_model #(
        .addr_bits (sram_addr_bits)
    ) sram_chip_model_inst (
        .ce_n (sram_ce_n),
        .we_n (sram_we_n),
        .oe_n (sram_oe_n),
        .ub_n (sram_ub_n),
        .lb_n (sram_lb_n),
        .addr (sram_addr),
        .dq   (sram_dq)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: no mem_ready after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // no access in flight means the part stays deselected
    always @(negedge clock) begin
        if (monitor_on && !outstanding) begin
            check("sram_ce_n", 64'(sram_ce_n), 64'h1);
        end
    end

    // each beat holds word index and beat index for beat_cycles cycles
    always @(negedge clock) begin
        if (sram_ce_n === 1'b0) begin
            check("sram_addr", 64'(sram_addr),
                  64'({expected_word, 2'(select_cycles / beat_cycles)}));
            select_cycles = select_cycles + 1;
        end else begin
            select_cycles = 0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] byte_addr(input logic [15:0] word);
        return {13'h0000, word, 3'b000};
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  strb);
        logic [63:0] result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_idle_outputs();
        check("mem_ready", 64'(mem_ready), 64'h0);
        check("mem_error", 64'(mem_error), 64'h0);
        check("sram_ce_n", 64'(sram_ce_n), 64'h1);
        check("sram_we_n", 64'(sram_we_n), 64'h1);
        check("sram_oe_n", 64'(sram_oe_n), 64'h1);
        check("sram_ub_n", 64'(sram_ub_n), 64'h1);
        check("sram_lb_n", 64'(sram_lb_n), 64'h1);
    endtask

    // one request, returns the response seen with mem_ready
    task automatic issue_request(input logic [31:0] addr, input logic [63:0] wdata,
                                 input logic [7:0] wstrb, output logic [63:0] rdata,
                                 output logic error, output int latency);
        @(negedge clock);
        check("mem_ready", 64'(mem_ready), 64'h0);  // previous pulse was one cycle wide
        mem_valid     = 1'b1;
        mem_addr      = addr;
        mem_wdata     = wdata;
        mem_wstrb     = wstrb;
        outstanding   = 1'b1;
        expected_word = addr[sram_addr_bits:3];
        @(negedge clock);
        mem_valid = 1'b0;
        latency   = 1;
        while (!mem_ready) begin
            @(negedge clock);
            latency = latency + 1;
        end
        rdata       = mem_rdata;
        error       = mem_error;
        outstanding = 1'b0;
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] r2;
        logic [3:0]  off;
        logic        refused;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
        logic [63:0] rdata;
        logic        err;
        int          latency;
        r       = rand32();
        off     = r[3:0];
        refused = (r[7:4] == 4'h0);
        wdata   = {rand32(), rand32()};
        wstrb   = 8'h00;
        if (r[8]) begin
            r2    = rand32();
            wstrb = (r2[9:8] == 2'b00) ? 8'hff : r2[7:0];
            if (wstrb == 8'h00) begin
                wstrb = 8'h01;  // zero strobes would turn it into a read
            end
        end
        addr = byte_addr(base_word + 16'(off));
        if (refused) begin
            addr = {r[31:20], 1'b1, addr[18:0]};    // aliases onto the window if it leaks
        end
        issue_request(addr, wdata, wstrb, rdata, err, latency);
        if (refused) begin
            check("mem_error", 64'(err), 64'h1);
            check("refused latency", 64'(latency), 64'h1);
            check("sram_ce_n", 64'(sram_ce_n), 64'h1);
        end else begin
            check("mem_error", 64'(err), 64'h0);
            if (wstrb != 8'h00) begin
                shadow[off] = merge_bytes(shadow[off], wdata, wstrb);
            end else begin
                check("mem_rdata", rdata, shadow[off]);
            end
        end
    endtask

    initial begin
        logic [63:0] rdata;
        logic        err;
        int          latency;
        clock         = 1'b0;
        reset         = 1'b0;
        mem_valid     = 1'b0;
        mem_addr      = '0;
        mem_wdata     = '0;
        mem_wstrb     = '0;
        outstanding   = 1'b0;
        monitor_on    = 1'b0;
        cycle_count   = 0;
        expected_word = '0;
        select_cycles = 0;
        rng_state     = 32'd56528;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 64'h0;
        end

        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clock);
            check_idle_outputs();
        end
        reset = 1'b1;
        @(negedge clock);
        check_idle_outputs();
        monitor_on = 1'b1;

        // top word of the part, never written
        issue_request(byte_addr(16'hffff), 64'h0, 8'h00, rdata, err, latency);
        check("mem_error", 64'(err), 64'h0);
        check("mem_rdata", rdata, 64'h0);

        issue_request(byte_addr(base_word), 64'h0123_4567_89ab_cdef, 8'hff, rdata, err, latency);
        check("mem_error", 64'(err), 64'h0);
        shadow[0] = merge_bytes(shadow[0], 64'h0123_4567_89ab_cdef, 8'hff);
        issue_request(byte_addr(base_word), 64'hfedc_ba98_7654_3210, 8'h5a, rdata, err, latency);
        check("mem_error", 64'(err), 64'h0);
        shadow[0] = merge_bytes(shadow[0], 64'hfedc_ba98_7654_3210, 8'h5a);
        issue_request(byte_addr(base_word), 64'h0, 8'h00, rdata, err, latency);
        check("mem_error", 64'(err), 64'h0);
        check("mem_rdata", rdata, 64'h01dc_4598_76ab_32ef);  // bytes 1, 3, 4 and 6 replaced

        for (int i = 0; i < total_ops - directed_ops; i++) begin
            random_op();
        end

        @(negedge clock);
        check("mem_ready", 64'(mem_ready), 64'h0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    // memory bus side
    localparam int addr_width = 32;     // byte address
    localparam int data_width = 64;
    localparam int strb_width = data_width / 8;

    // sram side
    localparam int dq_width = 16;
    localparam int beats    = data_width / dq_width;

    // decoded request, write when any strobe is set
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // pin sequencer
    typedef enum logic [1:0] {
        seq_idle = 2'd0,    // pins inactive, waiting for req_start
        seq_beat = 2'd1,    // one of the four beats on the pins
        seq_done = 2'd2     // last beat finished, answer the bus
    } seq_state_t;

endpackage

`default_nettype wire

// ==== sram_sequencer.sv ====
`default_nettype none

module sram_sequencer #(
    parameter int beat_cycles    = 3,
    parameter int sram_addr_bits = 18
) (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire                                  req_start,
    input  wire  sram_pkg::mem_op_t              req_op,
    input  wire  [sram_addr_bits-$clog2(sram_pkg::beats)-1:0] req_word,
    input  wire  [sram_pkg::data_width-1:0]      req_wdata,
    input  wire  [sram_pkg::strb_width-1:0]      req_wstrb,
    output logic                                 seq_done,
    output logic [sram_pkg::data_width-1:0]      seq_rdata,
    output logic                                 sram_ce_n,
    output logic                                 sram_we_n,
    output logic                                 sram_oe_n,
    output logic                                 sram_ub_n,
    output logic                                 sram_lb_n,
    output logic [sram_addr_bits-1:0]            sram_addr,
    inout  wire  [sram_pkg::dq_width-1:0]        sram_dq
);

    localparam int beat_bits = $clog2(sram_pkg::beats);
    localparam int cnt_bits  = (beat_cycles > 1) ? $clog2(beat_cycles) : 1;
    localparam logic [cnt_bits-1:0]  last_cnt  = cnt_bits'(beat_cycles - 1);
    localparam logic [beat_bits-1:0] last_beat = beat_bits'(sram_pkg::beats - 1);

    sram_pkg::seq_state_t state_q;
    sram_pkg::seq_state_t state_d;

    logic [cnt_bits-1:0]  cnt_q;
    logic [cnt_bits-1:0]  cnt_d;
    logic [beat_bits-1:0] beat_q;
    logic [beat_bits-1:0] beat_d;
    logic                 capture;

    // next pin values
    logic                          active;
    logic                          is_write;
    logic                          ce_n_d;
    logic                          we_n_d;
    logic                          oe_n_d;
    logic                          ub_n_d;
    logic                          lb_n_d;
    logic [sram_pkg::dq_width-1:0] dq_d;
    logic [sram_pkg::dq_width-1:0] dq_q;

    // req_* stays stable for the whole access, the request stage only reloads it when idle
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        beat_d  = beat_q;
        capture = 1'b0;
        case (state_q)
            sram_pkg::seq_idle: begin
                if (req_start) begin
                    state_d = sram_pkg::seq_beat;
                    cnt_d   = '0;
                    beat_d  = '0;
                end
            end
            sram_pkg::seq_beat: begin
                if (cnt_q == last_cnt) begin
                    capture = (req_op == sram_pkg::op_read);   // dq has settled by now
                    cnt_d   = '0;
                    if (beat_q == last_beat) begin
                        state_d = sram_pkg::seq_done;
                    end else begin
                        beat_d = beat_q + 1'b1;
                    end
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            sram_pkg::seq_done: begin
                state_d = sram_pkg::seq_idle;
            end
            default: begin
                state_d = sram_pkg::seq_idle;
            end
        endcase
    end

    assign active   = (state_d == sram_pkg::seq_beat);
    assign is_write = (req_op == sram_pkg::op_write);

    always_comb begin
        ce_n_d = ~active;
        we_n_d = ~(active & is_write);
        oe_n_d = ~(active & ~is_write);
        ub_n_d = 1'b1;
        lb_n_d = 1'b1;
        if (active) begin
            if (is_write) begin
                // strobe pair of this halfword, upper byte on ub
                ub_n_d = ~req_wstrb[{beat_d, 1'b1}];
                lb_n_d = ~req_wstrb[{beat_d, 1'b0}];
            end else begin
                ub_n_d = 1'b0;
                lb_n_d = 1'b0;
            end
        end
        dq_d = req_wdata[beat_d*sram_pkg::dq_width +: sram_pkg::dq_width];
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state_q   <= sram_pkg::seq_idle;
            cnt_q     <= '0;
            beat_q    <= '0;
            sram_ce_n <= 1'b1;
            sram_we_n <= 1'b1;
            sram_oe_n <= 1'b1;
            sram_ub_n <= 1'b1;
            sram_lb_n <= 1'b1;
        end else begin
            state_q   <= state_d;
            cnt_q     <= cnt_d;
            beat_q    <= beat_d;
            sram_ce_n <= ce_n_d;
            sram_we_n <= we_n_d;
            sram_oe_n <= oe_n_d;
            sram_ub_n <= ub_n_d;
            sram_lb_n <= lb_n_d;
        end
    end

    // address and write data only matter while ce_n is low
    always_ff @(posedge clock) begin
        sram_addr <= {req_word, beat_d};
        dq_q      <= dq_d;
    end

    // beat 0 lands in the low halfword
    always_ff @(posedge clock) begin
        if (capture) begin
            seq_rdata[beat_q*sram_pkg::dq_width +: sram_pkg::dq_width] <= sram_dq;
        end
    end

    assign sram_dq  = sram_we_n ? {sram_pkg::dq_width{1'bz}} : dq_q;
    assign seq_done = (state_q == sram_pkg::seq_done);

    // never drive against the part
    assert property (@(posedge clock) disable iff (!reset)
        !(!sram_we_n && !sram_oe_n))
        else $error("sram_we_n and sram_oe_n both low");

    assert property (@(posedge clock) disable iff (!reset)
        (state_q == sram_pkg::seq_idle) |-> sram_ce_n)
        else $error("sram selected while sequencer idle");

endmodule

`default_nettype wire
